// File: verilog/core_defines.svh
// starsea core widths, memory depths and address map
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and address width
`define CORE_XLEN 32

// register index width
`define CORE_REG_AW 5

// word-address widths, 256 words each
`define CORE_IRAM_AW 8
`define CORE_DRAM_AW 8

// addresses with this bit set go to the peripheral register bus
`define CORE_PERIPH_BIT 31

// data RAM window starts here, below the peripheral space
`define CORE_DRAM_BASE 32'h4000_0000

`endif

// File: verilog/core_pkg.sv
// starsea core shared types for words, register indices, opcodes and ALU operations
`include "core_defines.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;

  typedef logic [`CORE_REG_AW-1:0] reg_idx_t;

  // only the major opcodes this core executes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    // lui just forwards the immediate
    ALU_PASS_B
  } alu_op_e;

endpackage

// File: verilog/core_iram.sv
// starsea instruction memory, written from outside and read one cycle after the fetch address
`timescale 1ns/1ps
`include "core_defines.svh"

module core_iram (
  input  logic                     clk,
  input  logic                     i_we,
  input  core_pkg::word_t          i_waddr,
  input  core_pkg::word_t          i_wdata,
  input  logic [`CORE_IRAM_AW-1:0] i_raddr,
  output core_pkg::word_t          o_rdata
);
  import core_pkg::*;

  word_t mem [0:(1 << `CORE_IRAM_AW)-1];

  // waddr is a word address
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr[`CORE_IRAM_AW-1:0]] <= i_wdata;
    end
    o_rdata <= mem[i_raddr];
  end

  // loading the word under the pc is only safe while the pc is held
  assert property (@(posedge clk)
    (i_we && (i_waddr[`CORE_IRAM_AW-1:0] == i_raddr)) |-> (i_raddr == $past(i_raddr)));

endmodule

// File: verilog/core_fetch.sv
// starsea fetch stage, program counter with external halt and the fetch valid bit
`timescale 1ns/1ps

module core_fetch (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            i_halt,
  output core_pkg::word_t o_pc,
  output logic            o_fetch_valid
);
  import core_pkg::*;

  localparam word_t PC_STEP = 4;

  // valid is delayed one cycle so it lines up with the registered iram read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_pc          <= '0;
      o_fetch_valid <= 1'b0;
    end else begin
      o_fetch_valid <= !i_halt;
      if (!i_halt) begin
        o_pc <= o_pc + PC_STEP;
      end
    end
  end

endmodule

// File: verilog/core_decode.sv
// starsea decode stage, field decode, immediates and the decode/execute register
`timescale 1ns/1ps

module core_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  core_pkg::word_t    i_inst,
  input  logic               i_inst_valid,
  output core_pkg::reg_idx_t o_rs1,
  output core_pkg::reg_idx_t o_rs2,
  input  core_pkg::word_t    i_rs1_data,
  input  core_pkg::word_t    i_rs2_data,
  output logic               o_ex_valid,
  output core_pkg::alu_op_e  o_ex_alu_op,
  output logic               o_ex_use_imm,
  output core_pkg::word_t    o_ex_imm,
  output core_pkg::reg_idx_t o_ex_rs1,
  output core_pkg::reg_idx_t o_ex_rs2,
  output core_pkg::word_t    o_ex_rs1_data,
  output core_pkg::word_t    o_ex_rs2_data,
  output core_pkg::reg_idx_t o_ex_rd,
  output logic               o_ex_wb_en,
  output logic               o_ex_load,
  output logic               o_ex_store
);
  import core_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  alu_op_e    alu_op;
  logic       use_imm;
  logic       wb_en;
  logic       is_load;
  logic       is_store;
  word_t      imm;

  // alt selects sub or sra
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  endfunction

  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rd     = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  // anything not matched falls through as a non-writing no-op
  always_comb begin
    alu_op   = ALU_ADD;
    use_imm  = 1'b0;
    imm      = {{20{i_inst[31]}}, i_inst[31:20]};
    wb_en    = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    case (i_inst[6:0])
      OPC_OP: begin
        alu_op = arith_op(funct3, funct7[5]);
        wb_en  = (funct7 == 7'h00) ||
                 ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      OPC_OP_IMM: begin
        alu_op  = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
        use_imm = 1'b1;
        wb_en   = 1'b1;
      end
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        imm     = {i_inst[31:12], 12'h000};
        use_imm = 1'b1;
        wb_en   = 1'b1;
      end
      OPC_LOAD: begin
        use_imm = 1'b1;
        wb_en   = (funct3 == 3'b010);
        is_load = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        imm      = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
        use_imm  = 1'b1;
        is_store = (funct3 == 3'b010);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_ex_valid <= 1'b0;
      o_ex_wb_en <= 1'b0;
      o_ex_load  <= 1'b0;
      o_ex_store <= 1'b0;
    end else begin
      o_ex_valid <= i_inst_valid;
      o_ex_wb_en <= i_inst_valid && wb_en && (rd != '0);
      o_ex_load  <= i_inst_valid && is_load;
      o_ex_store <= i_inst_valid && is_store;
    end
  end

  always_ff @(posedge clk) begin
    o_ex_alu_op   <= alu_op;
    o_ex_use_imm  <= use_imm;
    o_ex_imm      <= imm;
    o_ex_rs1      <= o_rs1;
    o_ex_rs2      <= o_rs2;
    o_ex_rs1_data <= i_rs1_data;
    o_ex_rs2_data <= i_rs2_data;
    o_ex_rd       <= rd;
  end

endmodule

// File: verilog/core_regfile.sv
// starsea register file, x1..x31 with x0 tied to zero and same-cycle write bypass
`timescale 1ns/1ps

module core_regfile (
  input  logic               clk,
  input  logic               rst_n,
  input  core_pkg::reg_idx_t i_rs1,
  input  core_pkg::reg_idx_t i_rs2,
  input  logic               i_we,
  input  core_pkg::reg_idx_t i_rd,
  input  core_pkg::word_t    i_wdata,
  output core_pkg::word_t    o_rs1_data,
  output core_pkg::word_t    o_rs2_data
);
  import core_pkg::*;

  word_t regs [1:31];

  // a write landing this cycle is visible to decode right away
  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0) begin
      read_port = '0;
    end else if (i_we && (i_rd == idx)) begin
      read_port = i_wdata;
    end else begin
      read_port = regs[idx];
    end
  endfunction

  always_ff @(posedge clk) begin
    if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = read_port(i_rs1);
  assign o_rs2_data = read_port(i_rs2);

  // decode already drops the write enable for rd 0
  assert property (@(posedge clk) disable iff (!rst_n) i_we |-> (i_rd != '0));

endmodule

// File: verilog/core_execute.sv
// starsea execute stage, operand forwarding, ALU and the execute/memory register
`timescale 1ns/1ps

module core_execute (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_ex_valid,
  input  core_pkg::alu_op_e  i_ex_alu_op,
  input  logic               i_ex_use_imm,
  input  core_pkg::word_t    i_ex_imm,
  input  core_pkg::reg_idx_t i_ex_rs1,
  input  core_pkg::reg_idx_t i_ex_rs2,
  input  core_pkg::word_t    i_ex_rs1_data,
  input  core_pkg::word_t    i_ex_rs2_data,
  input  core_pkg::reg_idx_t i_ex_rd,
  input  logic               i_ex_wb_en,
  input  logic               i_ex_load,
  input  logic               i_ex_store,
  input  core_pkg::reg_idx_t i_mem_rd,
  input  logic               i_mem_wb_en,
  input  core_pkg::word_t    i_mem_result,
  output logic               o_mem_valid,
  output core_pkg::word_t    o_mem_addr_result,
  output core_pkg::word_t    o_mem_store_data,
  output core_pkg::reg_idx_t o_mem_rd,
  output logic               o_mem_wb_en,
  output logic               o_mem_load,
  output logic               o_mem_store
);
  import core_pkg::*;

  logic       fwd_rs1;
  logic       fwd_rs2;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_res;

  // the memory stage result covers load data too, so a load can feed the next instruction
  assign fwd_rs1 = i_mem_wb_en && (i_mem_rd != '0) && (i_mem_rd == i_ex_rs1);
  assign fwd_rs2 = i_mem_wb_en && (i_mem_rd != '0) && (i_mem_rd == i_ex_rs2);
  assign rs1_val = fwd_rs1 ? i_mem_result : i_ex_rs1_data;
  assign rs2_val = fwd_rs2 ? i_mem_result : i_ex_rs2_data;

  assign op_b  = i_ex_use_imm ? i_ex_imm : rs2_val;
  assign shamt = op_b[4:0];

  // loads and stores use the add path for the effective address
  always_comb begin
    case (i_ex_alu_op)
      ALU_ADD:  alu_res = rs1_val + op_b;
      ALU_SUB:  alu_res = rs1_val - op_b;
      ALU_AND:  alu_res = rs1_val & op_b;
      ALU_OR:   alu_res = rs1_val | op_b;
      ALU_XOR:  alu_res = rs1_val ^ op_b;
      ALU_SLL:  alu_res = rs1_val << shamt;
      ALU_SRL:  alu_res = rs1_val >> shamt;
      ALU_SRA:  alu_res = word_t'($signed(rs1_val) >>> shamt);
      ALU_SLT:  alu_res = word_t'($signed(rs1_val) < $signed(op_b));
      ALU_SLTU: alu_res = word_t'(rs1_val < op_b);
      default:  alu_res = op_b;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_mem_valid <= 1'b0;
      o_mem_wb_en <= 1'b0;
      o_mem_load  <= 1'b0;
      o_mem_store <= 1'b0;
    end else begin
      o_mem_valid <= i_ex_valid;
      o_mem_wb_en <= i_ex_wb_en;
      o_mem_load  <= i_ex_load;
      o_mem_store <= i_ex_store;
    end
  end

  always_ff @(posedge clk) begin
    o_mem_addr_result <= alu_res;
    o_mem_store_data  <= rs2_val;
    o_mem_rd          <= i_ex_rd;
  end

  // decode sets at most one of the two, from one opcode
  assert property (@(posedge clk) disable iff (!rst_n) !(o_mem_load && o_mem_store));

endmodule

// File: verilog/core_dmem.sv
// starsea memory stage, data RAM, peripheral register bus and the writeback result
`timescale 1ns/1ps
`include "core_defines.svh"

module core_dmem (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_mem_valid,
  input  core_pkg::word_t    i_mem_addr_result,
  input  core_pkg::word_t    i_mem_store_data,
  input  core_pkg::reg_idx_t i_mem_rd,
  input  logic               i_mem_wb_en,
  input  logic               i_mem_load,
  input  logic               i_mem_store,
  input  core_pkg::word_t    i_reg_bus_rdat,
  output logic               o_reg_bus_we,
  output core_pkg::word_t    o_reg_bus_addr,
  output core_pkg::word_t    o_reg_bus_wdat,
  output logic               o_reg_bus_rd,
  output logic               o_wb_en,
  output core_pkg::reg_idx_t o_wb_rd,
  output core_pkg::word_t    o_wb_data
);
  import core_pkg::*;

  word_t                    ram [0:(1 << `CORE_DRAM_AW)-1];
  logic                     periph;
  word_t                    ram_off;
  logic [`CORE_DRAM_AW-1:0] ram_idx;
  logic                     ram_we;
  word_t                    load_data;

  assign periph  = i_mem_addr_result[`CORE_PERIPH_BIT];
  assign ram_off = i_mem_addr_result - `CORE_DRAM_BASE;
  assign ram_idx = ram_off[`CORE_DRAM_AW+1:2];
  assign ram_we  = i_mem_valid && i_mem_store && !periph;

  // array read is combinational off the registered address, so load data is ready in this cycle
  always_ff @(posedge clk) begin
    if (ram_we) begin
      ram[ram_idx] <= i_mem_store_data;
    end
  end

  // bus strobes last exactly the one memory cycle, everything else stays at zero
  assign o_reg_bus_we   = i_mem_valid && i_mem_store && periph;
  assign o_reg_bus_rd   = i_mem_valid && i_mem_load && periph;
  assign o_reg_bus_addr = (o_reg_bus_we || o_reg_bus_rd) ? i_mem_addr_result : '0;
  assign o_reg_bus_wdat = o_reg_bus_we ? i_mem_store_data : '0;

  assign load_data = periph ? i_reg_bus_rdat : ram[ram_idx];

  // also the forwarding source for execute
  assign o_wb_en   = i_mem_valid && i_mem_wb_en;
  assign o_wb_rd   = i_mem_rd;
  assign o_wb_data = i_mem_load ? load_data : i_mem_addr_result;

  // only word accesses exist, the address comes from the execute adder
  assert property (@(posedge clk) disable iff (!rst_n)
    (i_mem_valid && (i_mem_load || i_mem_store) && !periph) |-> (ram_off[1:0] == 2'b00));

endmodule

// File: verilog/starsea_core.sv
// starsea core top level, four-stage RV32I subset pipeline with a peripheral register bus
`timescale 1ns/1ps
`include "core_defines.svh"

module starsea_core (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            i_halt,
  input  logic            i_iram_we,
  input  core_pkg::word_t i_iram_waddr,
  input  core_pkg::word_t i_iram_wdata,
  output logic            o_reg_bus_we,
  output core_pkg::word_t o_reg_bus_addr,
  output core_pkg::word_t o_reg_bus_wdat,
  output logic            o_reg_bus_rd,
  input  core_pkg::word_t i_reg_bus_rdat
);
  import core_pkg::*;

  word_t    pc;
  word_t    inst;
  logic     fetch_valid;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  alu_op_e  ex_alu_op;
  logic     ex_valid, ex_use_imm, ex_wb_en, ex_load, ex_store;
  word_t    ex_imm, ex_rs1_data, ex_rs2_data;
  reg_idx_t ex_rs1, ex_rs2, ex_rd;
  logic     mem_valid, mem_wb_en, mem_load, mem_store;
  word_t    mem_addr_result, mem_store_data;
  reg_idx_t mem_rd;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  core_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .i_halt(i_halt),
    .o_pc(pc), .o_fetch_valid(fetch_valid)
  );

  core_iram u_iram (
    .clk(clk), .i_we(i_iram_we), .i_waddr(i_iram_waddr), .i_wdata(i_iram_wdata),
    .i_raddr(pc[`CORE_IRAM_AW+1:2]), .o_rdata(inst)
  );

  core_decode u_decode (
    .clk(clk), .rst_n(rst_n), .i_inst(inst), .i_inst_valid(fetch_valid),
    .o_rs1(rs1), .o_rs2(rs2), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_ex_valid(ex_valid), .o_ex_alu_op(ex_alu_op), .o_ex_use_imm(ex_use_imm),
    .o_ex_imm(ex_imm), .o_ex_rs1(ex_rs1), .o_ex_rs2(ex_rs2),
    .o_ex_rs1_data(ex_rs1_data), .o_ex_rs2_data(ex_rs2_data), .o_ex_rd(ex_rd),
    .o_ex_wb_en(ex_wb_en), .o_ex_load(ex_load), .o_ex_store(ex_store)
  );

  core_regfile u_regfile (
    .clk(clk), .rst_n(rst_n), .i_rs1(rs1), .i_rs2(rs2),
    .i_we(wb_en), .i_rd(wb_rd), .i_wdata(wb_data),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  core_execute u_execute (
    .clk(clk), .rst_n(rst_n), .i_ex_valid(ex_valid), .i_ex_alu_op(ex_alu_op),
    .i_ex_use_imm(ex_use_imm), .i_ex_imm(ex_imm), .i_ex_rs1(ex_rs1), .i_ex_rs2(ex_rs2),
    .i_ex_rs1_data(ex_rs1_data), .i_ex_rs2_data(ex_rs2_data), .i_ex_rd(ex_rd),
    .i_ex_wb_en(ex_wb_en), .i_ex_load(ex_load), .i_ex_store(ex_store),
    .i_mem_rd(wb_rd), .i_mem_wb_en(wb_en), .i_mem_result(wb_data),
    .o_mem_valid(mem_valid), .o_mem_addr_result(mem_addr_result),
    .o_mem_store_data(mem_store_data), .o_mem_rd(mem_rd), .o_mem_wb_en(mem_wb_en),
    .o_mem_load(mem_load), .o_mem_store(mem_store)
  );

  core_dmem u_dmem (
    .clk(clk), .rst_n(rst_n), .i_mem_valid(mem_valid),
    .i_mem_addr_result(mem_addr_result), .i_mem_store_data(mem_store_data),
    .i_mem_rd(mem_rd), .i_mem_wb_en(mem_wb_en), .i_mem_load(mem_load),
    .i_mem_store(mem_store), .i_reg_bus_rdat(i_reg_bus_rdat),
    .o_reg_bus_we(o_reg_bus_we), .o_reg_bus_addr(o_reg_bus_addr),
    .o_reg_bus_wdat(o_reg_bus_wdat), .o_reg_bus_rd(o_reg_bus_rd),
    .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data)
  );

endmodule

// File: verification/core_ref_model.svh
// starsea reference model, random program generator and instruction-set interpreter
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

localparam int         PROG_LEN = 200;
localparam logic [6:0] OP_REG   = 7'b0110011;
localparam logic [6:0] OP_IMM   = 7'b0010011;
localparam logic [6:0] OP_LUI   = 7'b0110111;
localparam logic [6:0] OP_LOAD  = 7'b0000011;
localparam logic [6:0] OP_STORE = 7'b0100011;

logic [31:0]              prog [0:(1 << `CORE_IRAM_AW)-1];
logic [31:0]              xreg [0:31];
logic [31:0]              ram_model [0:(1 << `CORE_DRAM_AW)-1];
logic [`CORE_DRAM_AW-1:0] written_idx [$];
logic [31:0]              exp_wr_addr [$];
logic [31:0]              exp_wr_data [$];
logic [31:0]              exp_rd_addr [$];
int                       prog_len;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, OP_LUI};
endfunction

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [`CORE_DRAM_AW-1:0] ram_index(input logic [31:0] addr);
  logic [31:0] off;
  off = addr - `CORE_DRAM_BASE;
  return off[`CORE_DRAM_AW+1:2];
endfunction

// one instruction of the architectural model, peripheral traffic goes to the queues
function automatic void exec_inst(input logic [31:0] w);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] res;
  logic        alt;
  a   = xreg[w[19:15]];
  b   = (w[6:0] == OP_REG) ? xreg[w[24:20]] : {{20{w[31]}}, w[31:20]};
  alt = w[30] && ((w[6:0] == OP_REG) || (w[14:12] == 3'b101));
  res = alu_model(w[14:12], alt, a, b);
  case (w[6:0])
    OP_LUI: res = {w[31:12], 12'h000};
    OP_LOAD: begin
      addr = a + b;
      if (addr[31]) begin
        // responder answers with the address folded into a fixed pattern
        res = addr ^ 32'hA5A5_0000;
        exp_rd_addr.push_back(addr);
      end else begin
        res = ram_model[ram_index(addr)];
      end
    end
    OP_STORE: begin
      addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
      if (addr[31]) begin
        exp_wr_addr.push_back(addr);
        exp_wr_data.push_back(xreg[w[24:20]]);
      end else begin
        ram_model[ram_index(addr)] = xreg[w[24:20]];
        written_idx.push_back(ram_index(addr));
      end
    end
    default: begin
    end
  endcase
  if ((w[6:0] != OP_STORE) && (w[11:7] != 5'd0)) begin
    xreg[w[11:7]] = res;
  end
endfunction

function automatic void emit(input logic [31:0] w);
  prog[prog_len] = w;
  prog_len++;
  exec_inst(w);
endfunction

// x1..x7 only, so most instructions depend on a recent one
function automatic logic [4:0] rand_reg();
  logic [31:0] r;
  r = rand_bits(3);
  return (r[2:0] == 3'd0) ? 5'd7 : {2'b00, r[2:0]};
endfunction

function automatic logic [11:0] imm_for(input logic [2:0] f3);
  logic [31:0] r;
  r = rand_bits(12);
  if (f3 == 3'b001) begin
    return {7'b0, r[4:0]};
  end
  if (f3 == 3'b101) begin
    return {1'b0, r[5], 5'b0, r[4:0]};
  end
  return r[11:0];
endfunction

function automatic void gen_program();
  int          k;
  logic [4:0]  ra;
  logic [4:0]  rb;
  logic [4:0]  rc;
  logic [2:0]  f3;
  logic        alt;
  logic [31:0] sel;
  logic [31:0] r;
  prog_len = 0;
  for (k = 0; k < 32; k++) begin
    xreg[k] = '0;
  end
  for (k = 1; k < 8; k++) begin
    emit(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'(k), OP_IMM));
  end
  while (prog_len < PROG_LEN - 5) begin
    ra  = rand_reg();
    rb  = rand_reg();
    rc  = rand_reg();
    sel = rand_bits(3);
    f3  = 3'(rand_bits(3));
    r   = rand_bits(1);
    alt = ((f3 == 3'b000) || (f3 == 3'b101)) && r[0];
    case (sel[2:0])
      3'd0, 3'd1: emit(enc_r({1'b0, alt, 5'b0}, rb, ra, f3, rc));
      3'd2: emit(enc_i(imm_for(f3), ra, f3, rc, OP_IMM));
      3'd3: emit(enc_u(20'(rand_bits(20)), rc));
      3'd4, 3'd5: begin
        emit(enc_u({8'h80, 12'(rand_bits(12))}, rb));
        emit(enc_s({1'b0, 9'(rand_bits(9)), 2'b00}, ra, rb));
      end
      3'd6: begin
        emit(enc_u(20'h40000, rb));
        emit(enc_s({2'b00, 8'(rand_bits(8)), 2'b00}, ra, rb));
      end
      default: begin
        if ((written_idx.size() == 0) || (rand_bits(1) == 1)) begin
          emit(enc_u({8'h80, 12'(rand_bits(12))}, rb));
          emit(enc_i({1'b0, 9'(rand_bits(9)), 2'b00}, rb, 3'b010, rc, OP_LOAD));
        end else begin
          emit(enc_u(20'h40000, rb));
          emit(enc_i({2'b00, written_idx[rand_bits(8) % written_idx.size()], 2'b00},
                     rb, 3'b010, rc, OP_LOAD));
        end
        // load result used by the very next instruction
        emit(enc_r(7'h00, rc, ra, 3'b000, rb));
      end
    endcase
  end
  while (prog_len < PROG_LEN - 3) begin
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd0, OP_IMM));
  end
  // end marker written to 0xffff_fff0
  emit(enc_u(20'h5A5A5, 5'd1));
  emit(enc_i(12'hFF0, 5'd0, 3'b000, 5'd2, OP_IMM));
  emit(enc_s(12'd0, 5'd1, 5'd2));
  for (k = prog_len; k < (1 << `CORE_IRAM_AW); k++) begin
    prog[k] = enc_i(12'(k), 5'd0, 3'b000, 5'd0, OP_IMM);
  end
endfunction

`endif

// File: verification/core_tb.sv
// starsea core testbench, random program checked against the reference model on the register bus
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb;

  localparam int TIMEOUT = 5000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        halt;
  logic        iram_we;
  logic [31:0] iram_waddr;
  logic [31:0] iram_wdata;
  logic [31:0] bus_rdat = '0;
  logic        bus_we;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdat;
  logic        bus_rd;
  logic [15:0] lfsr;
  logic        quiet;
  logic        aborted;
  int          wr_idx = 0;
  int          rd_idx = 0;
  int          n_mismatch = 0;
  int          n_other = 0;
  int          n_flow;

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  `include "core_ref_model.svh"

  starsea_core dut0 (
    .clk(clk), .rst_n(rst_n), .i_halt(halt),
    .i_iram_we(iram_we), .i_iram_waddr(iram_waddr), .i_iram_wdata(iram_wdata),
    .o_reg_bus_we(bus_we), .o_reg_bus_addr(bus_addr), .o_reg_bus_wdat(bus_wdat),
    .o_reg_bus_rd(bus_rd), .i_reg_bus_rdat(bus_rdat)
  );

  always #2 clk = ~clk;

  // read data follows the strobe within the same memory cycle
  always @(posedge clk) begin
    #1;
    bus_rdat = bus_rd ? (bus_addr ^ 32'hA5A5_0000) : '0;
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (quiet && (bus_we || bus_rd || (bus_addr != '0) || (bus_wdat != '0))) begin
      n_other++;
      $display("bus active while idle at %0t: we=%0b rd=%0b", $time, bus_we, bus_rd);
    end
    if (bus_we) begin
      if (wr_idx >= exp_wr_addr.size()) begin
        n_other++;
        $display("unexpected peripheral write to %h at %0t", bus_addr, $time);
      end else begin
        if (bus_addr !== exp_wr_addr[wr_idx]) begin
          n_mismatch++;
          $display("MISMATCH o_reg_bus_addr write %0d: got %h expected %h",
                   wr_idx, bus_addr, exp_wr_addr[wr_idx]);
        end
        if (bus_wdat !== exp_wr_data[wr_idx]) begin
          n_mismatch++;
          $display("MISMATCH o_reg_bus_wdat write %0d: got %h expected %h",
                   wr_idx, bus_wdat, exp_wr_data[wr_idx]);
        end
        wr_idx++;
      end
    end
    if (bus_rd) begin
      if (rd_idx >= exp_rd_addr.size()) begin
        n_other++;
        $display("unexpected peripheral read from %h at %0t", bus_addr, $time);
      end else begin
        if (bus_addr !== exp_rd_addr[rd_idx]) begin
          n_mismatch++;
          $display("MISMATCH o_reg_bus_addr read %0d: got %h expected %h",
                   rd_idx, bus_addr, exp_rd_addr[rd_idx]);
        end
        rd_idx++;
      end
    end
  end

  task automatic load_program();
    int a;
    for (a = 0; a < (1 << `CORE_IRAM_AW); a++) begin
      @(posedge clk);
      #1;
      iram_we    = 1'b1;
      iram_waddr = a;
      iram_wdata = prog[a];
    end
    @(posedge clk);
    #1 iram_we = 1'b0;
  endtask

  task automatic wait_writes(input int target);
    int cyc;
    cyc = 0;
    while ((wr_idx < target) && (cyc < TIMEOUT)) begin
      @(posedge clk);
      cyc++;
    end
    if (wr_idx < target) begin
      n_flow++;
      aborted = 1'b1;
      $display("timed out after %0d cycles waiting for peripheral write %0d", TIMEOUT, target);
    end
  endtask

  // three edges drain fetch, execute and memory
  task automatic pause_run();
    int skew;
    int len;
    skew = rand_bits(3);
    len  = 5 + rand_bits(5);
    repeat (skew) @(posedge clk);
    @(posedge clk);
    #1 halt = 1'b1;
    repeat (3) @(posedge clk);
    #1 quiet = 1'b1;
    repeat (len) @(posedge clk);
    #1;
    quiet = 1'b0;
    halt  = 1'b0;
  endtask

  initial begin
    rst_n      = 1'b0;
    halt       = 1'b1;
    iram_we    = 1'b0;
    iram_waddr = '0;
    iram_wdata = '0;
    quiet      = 1'b1;
    aborted    = 1'b0;
    n_flow     = 0;
    lfsr       = 16'd14821;
    gen_program();
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    load_program();
    @(posedge clk);
    #1;
    quiet = 1'b0;
    halt  = 1'b0;
    wait_writes(exp_wr_addr.size() / 2);
    if (!aborted) begin
      pause_run();
      wait_writes(exp_wr_addr.size());
    end
    repeat (4) @(posedge clk);
    if (rd_idx != exp_rd_addr.size()) begin
      n_flow++;
      $display("only %0d of %0d peripheral reads were seen", rd_idx, exp_rd_addr.size());
    end
    $display("errors: %0d mismatch, %0d bus protocol, %0d flow", n_mismatch, n_other, n_flow);
    if ((n_mismatch + n_other + n_flow) == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+verilog
+incdir+verification
verilog/core_pkg.sv
verilog/core_iram.sv
verilog/core_fetch.sv
verilog/core_decode.sv
verilog/core_regfile.sv
verilog/core_execute.sv
verilog/core_dmem.sv
verilog/starsea_core.sv
verification/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the starsea core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module core_tb -o core_tb_sim

# a failing run or a missing pass line both count as failure
out=$(./obj_dir/core_tb_sim) || true
echo "$out"
echo "$out" | grep -qx "sim passed"
